//--- source/execute_pkg.sv
// Execute stage shared types: micro-operation fields, unit encodings and data memory bus
package execute_pkg;

    localparam int XLEN = 32;

    typedef enum logic [2:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV,
        UNIT_LSU
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } branch_op_e;

    typedef enum logic [1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU
    } div_op_e;

    typedef enum logic [2:0] {
        MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef struct packed {
        unit_e      unit;
        alu_op_e    alu_op;
        branch_op_e branch_op;
        mul_op_e    mul_op;
        div_op_e    div_op;
        mem_op_e    mem_op;
        logic       rd_we;
        logic       link;       // Rd gets pc_next, not the unit result
    } uop_t;

    // Operand relation, worked out in decode
    typedef struct packed {
        logic lt;
        logic ltu;
        logic eq;
    } compare_t;

    typedef struct packed {
        logic            rd_we;
        logic            link;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] rd_value;
        logic [31:1]     pc_next;
    } writeback_t;

    typedef struct packed {
        logic            sel;
        logic            we;
        logic [XLEN-1:0] addr;    // Word aligned
        logic [XLEN-1:0] wdata;
        logic [3:0]      mask;    // One bit per byte lane
    } dmem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            stall;
    } dmem_rsp_t;

endpackage

//--- source/alu.sv
// ALU: RV32I arithmetic, logic, shift and compare, also the adder for addresses and targets
module alu (
    input  execute_pkg::alu_op_e         op_i,
    input  logic [execute_pkg::XLEN-1:0] a_i,
    input  logic [execute_pkg::XLEN-1:0] b_i,
    output logic [execute_pkg::XLEN-1:0] result_o
);

    import execute_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            ALU_SLT:  result_o = XLEN'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = XLEN'(a_i < b_i);
            default:  result_o = b_i;           // PASS_B for LUI
        endcase
    end

endmodule

//--- source/multiplier.sv
// Multiplier: signed/unsigned 32x32 product through a valid-tagged pipeline
module multiplier #(
    parameter int MUL_STAGES = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  execute_pkg::mul_op_e op_i,
    input  logic [31:0]          a_i,
    input  logic [31:0]          b_i,
    output logic [31:0]          result_o,
    output logic                 done_o
);

    import execute_pkg::*;

    typedef struct packed {
        logic        high;      // Upper word wanted
        logic [63:0] product;
    } stage_t;

    logic                  sign_a;
    logic                  sign_b;
    logic signed [32:0]    a_ext;
    logic signed [32:0]    b_ext;
    logic signed [65:0]    product_full;
    stage_t                stage_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] valid_q;

    // MULHSU is signed times unsigned
    assign sign_a = (op_i == MUL_MULH) || (op_i == MUL_MULHSU);
    assign sign_b = (op_i == MUL_MULH);
    assign a_ext = {sign_a & a_i[31], a_i};
    assign b_ext = {sign_b & b_i[31], b_i};
    assign product_full = a_ext * b_ext;

    always_ff @(posedge clk_i) begin
        stage_q[0].high    <= (op_i != MUL_MUL);
        stage_q[0].product <= product_full[63:0];
        for (int i = 1; i < MUL_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= MUL_STAGES'({valid_q, start_i}); // Tag follows its product
        end
    end

    assign done_o   = valid_q[MUL_STAGES-1];
    assign result_o = stage_q[MUL_STAGES-1].high ? stage_q[MUL_STAGES-1].product[63:32]
                                                 : stage_q[MUL_STAGES-1].product[31:0];

endmodule

//--- source/divider.sv
// Divider: iterative restoring divide giving RV32M quotient and remainder in 33 cycles
module divider (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  execute_pkg::div_op_e op_i,
    input  logic [31:0]          dividend_i,
    input  logic [31:0]          divisor_i,
    output logic [31:0]          result_o,
    output logic                 done_o
);

    import execute_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e      state_q;
    logic [4:0]  count_q;
    div_op_e     op_q;
    logic [31:0] dividend_q;    // Kept for the divide-by-zero remainder
    logic [31:0] divisor_q;
    logic [31:0] quot_q;
    logic [31:0] rem_q;
    logic        zero_q;
    logic        quot_neg_q;
    logic        rem_neg_q;
    logic        is_signed;
    logic [31:0] dividend_abs;
    logic [31:0] divisor_abs;
    logic [33:0] trial;

    assign is_signed    = (op_i == DIV_DIV) || (op_i == DIV_REM);
    assign dividend_abs = (is_signed && dividend_i[31]) ? -dividend_i : dividend_i;
    assign divisor_abs  = (is_signed && divisor_i[31]) ? -divisor_i : divisor_i;

    // Shift in next dividend bit and try the subtract, bit 33 is the borrow
    assign trial = {1'b0, rem_q, quot_q[31]} - {2'b00, divisor_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    count_q <= '0;
                    if (start_i) begin
                        state_q <= RUN;
                    end
                end
                RUN: begin
                    count_q <= count_q + 5'd1;
                    if (count_q == 5'd31) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            op_q       <= op_i;
            dividend_q <= dividend_i;
            divisor_q  <= divisor_abs;
            quot_q     <= dividend_abs;     // Shifts out as quotient bits shift in
            rem_q      <= '0;
            zero_q     <= (divisor_i == '0);
            quot_neg_q <= is_signed && (dividend_i[31] ^ divisor_i[31]);
            rem_neg_q  <= is_signed && dividend_i[31];
        end else if (state_q == RUN) begin
            quot_q <= {quot_q[30:0], ~trial[33]};
            rem_q  <= trial[33] ? {rem_q[30:0], quot_q[31]} : trial[31:0];
        end
    end

    // Sign fix. Overflow falls out of the magnitude path unchanged
    always_comb begin
        case (op_q)
            DIV_DIV, DIV_DIVU: result_o = zero_q ? '1 : (quot_neg_q ? -quot_q : quot_q);
            default:           result_o = zero_q ? dividend_q : (rem_neg_q ? -rem_q : rem_q);
        endcase
    end

    assign done_o = (state_q == DONE);

endmodule

//--- source/load_store_unit.sv
// Load-store unit: byte/half/word accesses on the L1 data port with lane alignment
module load_store_unit (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  execute_pkg::mem_op_e   op_i,
    input  logic [31:0]            addr_i,
    input  logic [31:0]            store_data_i,
    output logic [31:0]            result_o,
    output logic                   done_o,
    output execute_pkg::dmem_req_t dmem_req_o,
    input  execute_pkg::dmem_rsp_t dmem_rsp_i
);

    import execute_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RESP
    } state_e;

    state_e      state_q;
    dmem_req_t   req_q;
    mem_op_e     op_q;
    logic [1:0]  lane_q;
    logic        is_store;
    logic [3:0]  mask;
    logic [31:0] load_word;

    assign is_store = (op_i inside {MEM_SB, MEM_SH, MEM_SW});

    always_comb begin
        case (op_i)
            MEM_SB:  mask = 4'b0001 << addr_i[1:0];
            MEM_SH:  mask = 4'b0011 << addr_i[1:0];
            default: mask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            req_q.sel <= 1'b0;
            req_q.we  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q     <= REQ;
                        req_q.sel   <= 1'b1;
                        req_q.we    <= is_store;
                        req_q.addr  <= {addr_i[31:2], 2'b00};
                        req_q.wdata <= store_data_i << {addr_i[1:0], 3'b000};
                        req_q.mask  <= mask;
                        op_q        <= op_i;
                        lane_q      <= addr_i[1:0];
                    end
                end
                REQ: begin
                    // Request stays put until memory takes it
                    if (!dmem_rsp_i.stall) begin
                        state_q   <= req_q.we ? IDLE : RESP;
                        req_q.sel <= 1'b0;
                        req_q.we  <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign load_word = dmem_rsp_i.rdata >> {lane_q, 3'b000};

    always_comb begin
        case (op_q)
            MEM_LB:  result_o = {{24{load_word[7]}}, load_word[7:0]};
            MEM_LBU: result_o = {24'b0, load_word[7:0]};
            MEM_LH:  result_o = {{16{load_word[15]}}, load_word[15:0]};
            MEM_LHU: result_o = {16'b0, load_word[15:0]};
            default: result_o = load_word;
        endcase
    end

    // Stores end on accept, loads when data returns
    assign done_o = (state_q == RESP) || (state_q == REQ && !dmem_rsp_i.stall && req_q.we);
    assign dmem_req_o = req_q;

endmodule

//--- source/execute_stage.sv
// Execute stage: ALU, branch resolve, multicycle units, result select and writeback register
module execute_stage #(
    parameter int MUL_STAGES = 2
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  execute_pkg::uop_t            uop_i,
    input  logic [4:0]                   rd_addr_i,
    input  logic [31:1]                  pc_next_i,
    input  logic [execute_pkg::XLEN-1:0] operand_a_i,
    input  logic [execute_pkg::XLEN-1:0] operand_b_i,
    input  logic [execute_pkg::XLEN-1:0] store_data_i,
    input  execute_pkg::compare_t        compare_i,
    output logic                         ready_o,
    output logic                         fwd_valid_o,
    output logic [execute_pkg::XLEN-1:0] fwd_value_o,
    output logic                         branch_taken_o,
    output logic [31:1]                  branch_target_o,
    output execute_pkg::writeback_t      wb_o,
    output execute_pkg::dmem_req_t       dmem_req_o,
    input  execute_pkg::dmem_rsp_t       dmem_rsp_i
);

    import execute_pkg::*;

    alu_op_e         alu_op;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_result;
    logic [XLEN-1:0] div_result;
    logic [XLEN-1:0] lsu_result;
    logic [XLEN-1:0] result;
    logic            mul_start;
    logic            div_start;
    logic            lsu_start;
    logic            mul_done;
    logic            div_done;
    logic            lsu_done;
    logic            launched_q;    // Current uop already started its unit

    // Address and target sums both go through the ALU adder
    assign alu_op = (uop_i.unit == UNIT_LSU || uop_i.branch_op != BR_NONE) ? ALU_ADD
                                                                           : uop_i.alu_op;

    alu alu_inst (
        .op_i     (alu_op),
        .a_i      (operand_a_i),
        .b_i      (operand_b_i),
        .result_o (alu_result)
    );

    assign mul_start = (uop_i.unit == UNIT_MUL) && !launched_q;
    assign div_start = (uop_i.unit == UNIT_DIV) && !launched_q;
    assign lsu_start = (uop_i.unit == UNIT_LSU) && !launched_q;

    multiplier #(
        .MUL_STAGES (MUL_STAGES)
    ) multiplier_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .op_i     (uop_i.mul_op),
        .a_i      (operand_a_i),
        .b_i      (operand_b_i),
        .result_o (mul_result),
        .done_o   (mul_done)
    );

    divider divider_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (uop_i.div_op),
        .dividend_i (operand_a_i),
        .divisor_i  (operand_b_i),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    load_store_unit load_store_unit_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (lsu_start),
        .op_i         (uop_i.mem_op),
        .addr_i       (alu_result),
        .store_data_i (store_data_i),
        .result_o     (lsu_result),
        .done_o       (lsu_done),
        .dmem_req_o   (dmem_req_o),
        .dmem_rsp_i   (dmem_rsp_i)
    );

    always_comb begin
        case (uop_i.unit)
            UNIT_MUL: ready_o = launched_q && mul_done;
            UNIT_DIV: ready_o = launched_q && div_done;
            UNIT_LSU: ready_o = launched_q && lsu_done;
            default:  ready_o = 1'b1;                   // Single cycle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            launched_q <= 1'b0;
        end else if (ready_o) begin
            launched_q <= 1'b0;
        end else if (mul_start || div_start || lsu_start) begin
            launched_q <= 1'b1;
        end
    end

    always_comb begin
        case (uop_i.branch_op)
            BR_EQ:           branch_taken_o = compare_i.eq;
            BR_NE:           branch_taken_o = !compare_i.eq;
            BR_LT:           branch_taken_o = compare_i.lt;
            BR_GE:           branch_taken_o = !compare_i.lt;
            BR_LTU:          branch_taken_o = compare_i.ltu;
            BR_GEU:          branch_taken_o = !compare_i.ltu;
            BR_JAL, BR_JALR: branch_taken_o = 1'b1;
            default:         branch_taken_o = 1'b0;     // Never a spurious redirect
        endcase
    end

    assign branch_target_o = alu_result[31:1];

    always_comb begin
        case (uop_i.unit)
            UNIT_MUL: result = mul_result;
            UNIT_DIV: result = div_result;
            UNIT_LSU: result = lsu_result;
            default:  result = alu_result;
        endcase
    end

    assign fwd_valid_o = !(uop_i.unit inside {UNIT_MUL, UNIT_DIV, UNIT_LSU});
    assign fwd_value_o = result;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o.rd_we <= 1'b0;
            wb_o.link  <= 1'b0;
        end else begin
            wb_o.rd_we <= ready_o && uop_i.rd_we;       // No write while waiting on a unit
            if (ready_o) begin
                wb_o.link     <= uop_i.link;
                wb_o.rd_addr  <= rd_addr_i;
                wb_o.rd_value <= result;
                wb_o.pc_next  <= pc_next_i;
            end
        end
    end

endmodule

//--- bench/execute_stage_tb.sv
// Testbench for the execute stage with random uops through every unit and a stalling data memory
module execute_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import execute_pkg::*;

    localparam int MUL_STAGES = 2;
    localparam int TIMEOUT    = 100;

    logic        clk_i;
    logic        rst_i;
    uop_t        uop;
    logic [4:0]  rd_addr;
    logic [31:1] pc_next;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] store_data;
    compare_t    compare;
    logic        ready;
    logic        fwd_valid;
    logic [31:0] fwd_value;
    logic        branch_taken;
    logic [31:1] branch_target;
    writeback_t  wb;
    dmem_req_t   dmem_req;
    dmem_rsp_t   dmem_rsp;

    logic [31:0] mem [256];
    logic [31:0] shadow [256];     // Expected memory contents
    int          seed = 32'ha665;
    int          stall_seed = 32'ha665;
    int          stall_run;
    logic        pending;          // Writeback of the last uop still to check
    writeback_t  exp_wb;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [3:0]  exp_mask;
    uop_t        u;
    compare_t    c;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sd;
    logic [31:0] expv;
    logic [31:0] base;
    logic [1:0]  lane;
    int          waited;

    execute_stage #(
        .MUL_STAGES (MUL_STAGES)
    ) execute_stage_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .uop_i           (uop),
        .rd_addr_i       (rd_addr),
        .pc_next_i       (pc_next),
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .store_data_i    (store_data),
        .compare_i       (compare),
        .ready_o         (ready),
        .fwd_valid_o     (fwd_valid),
        .fwd_value_o     (fwd_value),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .wb_o            (wb),
        .dmem_req_o      (dmem_req),
        .dmem_rsp_i      (dmem_rsp)
    );

    always #50 clk_i = ~clk_i;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("ERR @ %0t ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] x, logic [31:0] y);
        case (op)
            ALU_ADD:  return x + y;
            ALU_SUB:  return x - y;
            ALU_AND:  return x & y;
            ALU_OR:   return x | y;
            ALU_XOR:  return x ^ y;
            ALU_SLL:  return x << y[4:0];
            ALU_SRL:  return x >> y[4:0];
            ALU_SRA:  return 32'($signed(x) >>> y[4:0]);
            ALU_SLT:  return {31'b0, $signed(x) < $signed(y)};
            ALU_SLTU: return {31'b0, x < y};
            default:  return y;                 // LUI
        endcase
    endfunction

    function automatic logic branch_ref(branch_op_e op, compare_t rel);
        case (op)
            BR_EQ:           return rel.eq;
            BR_NE:           return !rel.eq;
            BR_LT:           return rel.lt;
            BR_GE:           return !rel.lt;
            BR_LTU:          return rel.ltu;
            BR_GEU:          return !rel.ltu;
            BR_JAL, BR_JALR: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    // Operands extended to 64 bits so the low 64 product bits are exact
    function automatic logic [31:0] mul_ref(mul_op_e op, logic [31:0] x, logic [31:0] y);
        logic [63:0] xe;
        logic [63:0] ye;
        logic [63:0] p;
        xe = (op == MUL_MULH || op == MUL_MULHSU) ? {{32{x[31]}}, x} : {32'b0, x};
        ye = (op == MUL_MULH) ? {{32{y[31]}}, y} : {32'b0, y};
        p  = xe * ye;
        return (op == MUL_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] div_ref(div_op_e op, logic [31:0] x, logic [31:0] y);
        logic is_rem;
        logic sgn;
        is_rem = (op == DIV_REM) || (op == DIV_REMU);
        sgn    = (op == DIV_DIV) || (op == DIV_REM);
        if (y == 32'd0) begin
            return is_rem ? x : 32'hffff_ffff;
        end
        if (sgn && x == 32'h8000_0000 && y == 32'hffff_ffff) begin
            return is_rem ? 32'd0 : x;
        end
        if (sgn && is_rem) begin
            return $signed(x) % $signed(y);
        end
        if (sgn) begin
            return $signed(x) / $signed(y);
        end
        return is_rem ? x % y : x / y;
    endfunction

    function automatic logic [31:0] load_ref(mem_op_e op, logic [31:0] word, logic [1:0] ln);
        logic [31:0] w;
        w = word >> {ln, 3'b000};
        case (op)
            MEM_LB:  return {{24{w[7]}}, w[7:0]};
            MEM_LBU: return {24'b0, w[7:0]};
            MEM_LH:  return {{16{w[15]}}, w[15:0]};
            MEM_LHU: return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [1:0] pick_lane(mem_op_e op, logic [1:0] r);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return r;
            MEM_LH, MEM_LHU, MEM_SH: return {r[1], 1'b0};
            default:                 return 2'b00;
        endcase
    endfunction

    function automatic logic [31:0] byte_lanes(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // Data memory with one cycle read latency and stall bursts of at most 4 cycles
    always @(posedge clk_i) begin
        if (rst_i) begin
            dmem_rsp.stall <= 1'b0;
            stall_run      <= 0;
        end else begin
            if (dmem_req.sel && !dmem_rsp.stall) begin
                if (dmem_req.we) begin
                    assert (dmem_req.addr == {exp_addr[31:2], 2'b00} && dmem_req.mask == exp_mask
                            && (dmem_req.wdata & byte_lanes(exp_mask))
                               == (exp_wdata & byte_lanes(exp_mask)))
                        else report_mismatch($sformatf("store addr %h mask %b data %h",
                                             dmem_req.addr, dmem_req.mask, dmem_req.wdata));
                    for (int i = 0; i < 4; i++) begin
                        if (dmem_req.mask[i]) begin
                            mem[dmem_req.addr[9:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
                        end
                    end
                end else begin
                    dmem_rsp.rdata <= mem[dmem_req.addr[9:2]];
                end
            end
            if (stall_run < 4 && ($random(stall_seed) & 1)) begin
                dmem_rsp.stall <= 1'b1;
                stall_run      <= stall_run + 1;
            end else begin
                dmem_rsp.stall <= 1'b0;
                stall_run      <= 0;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_req.sel && dmem_rsp.stall |=> $stable(dmem_req))
        else report_mismatch("dmem request changed while stalled");

    assert property (@(posedge clk_i) disable iff (rst_i) !ready |=> !wb.rd_we)
        else report_mismatch("writeback enabled while ready_o was low");

    assert property (@(posedge clk_i) disable iff (rst_i)
        uop.unit inside {UNIT_MUL, UNIT_DIV, UNIT_LSU} |-> !fwd_valid)
        else report_mismatch("fwd_valid_o high for a multicycle unit");

    task automatic check_pending();
        if (pending) begin
            assert (wb.rd_we == exp_wb.rd_we && wb.rd_addr == exp_wb.rd_addr
                    && wb.link == exp_wb.link)
                else report_mismatch($sformatf("wb we/rd/link %b/%0d/%b, expected %b/%0d/%b",
                                     wb.rd_we, wb.rd_addr, wb.link,
                                     exp_wb.rd_we, exp_wb.rd_addr, exp_wb.link));
            if (exp_wb.link) begin
                assert (wb.pc_next == exp_wb.pc_next)
                    else report_mismatch($sformatf("wb pc_next %h, expected %h",
                                         wb.pc_next, exp_wb.pc_next));
            end else if (exp_wb.rd_we) begin
                assert (wb.rd_value == exp_wb.rd_value)
                    else report_mismatch($sformatf("wb value %h, expected %h",
                                         wb.rd_value, exp_wb.rd_value));
            end
            pending = 1'b0;
        end
    endtask

    // Drive one uop, then stay at the negedge of its ready cycle
    task automatic issue(input uop_t nu, input logic [31:0] x, input logic [31:0] y,
                         input logic [31:0] sdata, input compare_t rel,
                         input logic [31:0] value, output int low_cycles);
        logic [4:0]  rd;
        logic [31:1] pc;
        rd = 5'($random(seed));
        pc = 31'($random(seed));
        @(posedge clk_i);
        uop        <= nu;
        rd_addr    <= rd;
        pc_next    <= pc;
        operand_a  <= x;
        operand_b  <= y;
        store_data <= sdata;
        compare    <= rel;
        @(negedge clk_i);
        check_pending();
        low_cycles = 0;
        while (!ready) begin
            low_cycles++;
            if (low_cycles > TIMEOUT) begin
                abort_run("Timeout: ready_o stayed low for more than 100 cycles");
            end
            @(negedge clk_i);
        end
        exp_wb.rd_we    = nu.rd_we;
        exp_wb.link     = nu.link;
        exp_wb.rd_addr  = rd;
        exp_wb.rd_value = value;
        exp_wb.pc_next  = pc;
        pending         = 1'b1;
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        uop        = '0;
        rd_addr    = '0;
        pc_next    = '0;
        operand_a  = '0;
        operand_b  = '0;
        store_data = '0;
        compare    = '0;
        dmem_rsp   = '0;
        pending    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
            shadow[i] = mem[i];
        end
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        assert (ready && !wb.rd_we && !dmem_req.sel && !dmem_req.we && !branch_taken)
            else report_mismatch("outputs not inactive after reset");

        repeat (40) begin
            u        = '0;
            u.unit   = UNIT_ALU;
            u.alu_op = alu_op_e'(4'({$random(seed)} % 11));
            u.rd_we  = 1'b1;
            a        = $random(seed);
            b        = $random(seed);
            expv     = alu_ref(u.alu_op, a, b);
            issue(u, a, b, 32'd0, '0, expv, waited);
            assert (waited == 0 && fwd_valid && fwd_value == expv)
                else report_mismatch($sformatf("forward %h, expected %h", fwd_value, expv));
        end

        for (int op = 1; op <= 8; op++) begin
            repeat (4) begin
                u           = '0;
                u.branch_op = branch_op_e'(4'(op));
                u.alu_op    = alu_op_e'(4'({$random(seed)} % 11)); // Target ignores it
                u.unit      = (op >= BR_JAL) ? UNIT_ALU : UNIT_NONE;
                u.rd_we     = (op >= BR_JAL);
                u.link      = (op >= BR_JAL);       // Jumps write the return address
                c           = compare_t'(3'($random(seed)));
                a           = $random(seed);
                b           = $random(seed);
                expv        = a + b;
                issue(u, a, b, 32'd0, c, expv, waited);
                assert (branch_taken == branch_ref(u.branch_op, c)
                        && branch_target == expv[31:1])
                    else report_mismatch($sformatf("branch %s taken %b target %h",
                                         u.branch_op.name(), branch_taken, branch_target));
            end
        end

        for (int op = 0; op < 4; op++) begin
            for (int k = 0; k < 4; k++) begin
                u        = '0;
                u.unit   = UNIT_MUL;
                u.mul_op = mul_op_e'(2'(op));
                u.rd_we  = 1'b1;
                a        = (k == 0) ? 32'h8000_0000 : $random(seed);
                b        = (k == 0) ? 32'hffff_ffff : $random(seed);
                issue(u, a, b, 32'd0, '0, mul_ref(u.mul_op, a, b), waited);
                assert (waited == MUL_STAGES)
                    else report_mismatch($sformatf("multiply held ready low %0d cycles", waited));
            end
        end

        for (int op = 0; op < 4; op++) begin
            for (int k = 0; k < 5; k++) begin
                u        = '0;
                u.unit   = UNIT_DIV;
                u.div_op = div_op_e'(2'(op));
                u.rd_we  = 1'b1;
                a        = (k == 1) ? 32'h8000_0000 : $random(seed);
                b        = $random(seed);
                if (k == 0) begin
                    b = 32'd0;
                end else if (k == 1) begin
                    b = 32'hffff_ffff;
                end else if (k == 4) begin
                    b = b & 32'hff;             // Small divisor for a wide quotient
                end
                issue(u, a, b, 32'd0, '0, div_ref(u.div_op, a, b), waited);
                assert (waited == 33)
                    else report_mismatch($sformatf("divide held ready low %0d cycles", waited));
            end
        end

        repeat (24) begin
            base      = $random(seed) & 32'h3fc;
            u         = '0;
            u.unit    = UNIT_LSU;
            u.alu_op  = alu_op_e'(4'({$random(seed)} % 11)); // Address is always a sum
            u.mem_op  = mem_op_e'(3'(5 + {$random(seed)} % 3));
            lane      = pick_lane(u.mem_op, 2'($random(seed)));
            sd        = $random(seed);
            exp_addr  = base + lane;
            exp_mask  = (u.mem_op == MEM_SB) ? 4'b0001 << lane
                      : (u.mem_op == MEM_SH) ? 4'b0011 << lane : 4'b1111;
            exp_wdata = sd << {lane, 3'b000};
            for (int i = 0; i < 4; i++) begin
                if (exp_mask[i]) begin
                    shadow[base[9:2]][8*i +: 8] = exp_wdata[8*i +: 8];
                end
            end
            issue(u, base, {30'b0, lane}, sd, '0, 32'd0, waited);

            u.mem_op = mem_op_e'(3'({$random(seed)} % 5));
            u.rd_we  = 1'b1;
            lane     = pick_lane(u.mem_op, 2'($random(seed)));
            expv     = load_ref(u.mem_op, shadow[base[9:2]], lane);
            issue(u, base, {30'b0, lane}, 32'd0, '0, expv, waited);
        end

        // Let the last writeback land
        @(posedge clk_i);
        uop <= '0;
        @(negedge clk_i);
        check_pending();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sources.f
source/execute_pkg.sv
source/alu.sv
source/multiplier.sv
source/divider.sv
source/load_store_unit.sv
source/execute_stage.sv
bench/execute_stage_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - source/execute_pkg.sv
  - source/alu.sv
  - source/multiplier.sv
  - source/divider.sv
  - source/load_store_unit.sv
  - source/execute_stage.sv
  - target: simulation
    files:
      - bench/execute_stage_tb.sv
